/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/exec_bus_if.sv */
// Decode to execute register
`timescale 1ns/1ps

interface exec_bus_if;

    // Live instruction marker, no handshake
    logic                  valid;
    rv_core_pkg::exec_op_e op;
    rv_core_pkg::word_t    pc;

    // Operands, rs2_data already holds the immediate for ALU immediates
    rv_core_pkg::word_t    rs1_data;
    rv_core_pkg::word_t    rs2_data;
    rv_core_pkg::word_t    imm;
    rv_core_pkg::reg_idx_t rd;

    // Decode owns the register
    modport decode_mp (output valid, op, pc, rs1_data, rs2_data, imm, rd);

    modport execute_mp (input valid, op, pc, rs1_data, rs2_data, imm, rd);

endinterface

/* common/rv_core_params.svh */
// Core configuration macros
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Address of the first instruction fetch
`define RESET_PC 32'h0000_0000

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define NUM_REGS 32

`endif

/* common/rv_core_pkg.sv */
// Pipeline types
`include "rv_core_params.svh"

package rv_core_pkg;

    // Data or address word
    typedef logic [`XLEN-1:0] word_t;

    // Register index
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // Operation carried from decode to retire
    typedef enum logic [3:0] {
        NOP,
        ADD,
        SUB,
        SLL,
        SLT,
        XOR,
        SRL,
        OR,
        AND,
        LUI,
        LW,
        SW,
        BEQ,
        BNE,
        JAL
    } exec_op_e;

    // Operations that produce a value for rd
    function automatic logic op_writes_rd(exec_op_e op);
        return !(op inside {NOP, SW, BEQ, BNE});
    endfunction

endpackage

/* common/rv_isa_pkg.sv */
// RV32I instruction encoding
`include "rv_core_params.svh"

package rv_isa_pkg;

    // Raw instruction word
    typedef logic [`XLEN-1:0] instr_t;

    // Function field, bits 14:12
    typedef logic [2:0] funct3_t;

    // Major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Upper function field, bits 31:25
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7_e;

    // ALU function codes, register and immediate forms
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SRL = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // Word size for loads and stores
    localparam funct3_t F3_WORD = 3'b010;

endpackage

/* decode/decode_unit.sv */
// Instruction decode stage
`timescale 1ns/1ps

module decode_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  valid_i,
    input  rv_core_pkg::word_t    pc_i,
    input  rv_core_pkg::word_t    instruction_i,
    input  logic                  jump_i,
    output rv_core_pkg::reg_idx_t rs1_o,
    output rv_core_pkg::reg_idx_t rs2_o,
    input  rv_core_pkg::word_t    rs1_data_i,
    input  rv_core_pkg::word_t    rs2_data_i,
    output logic                  hazard_o,
    exec_bus_if.decode_mp         exec_bus
);

    ////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////

    rv_isa_pkg::instr_t    instr;
    rv_isa_pkg::opcode_e   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_e   funct7;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::exec_op_e op;
    rv_core_pkg::word_t    imm;
    logic                  imm_operand;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  ex_writes;

    assign instr  = instruction_i;
    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = rv_isa_pkg::funct7_e'(instr[31:25]);
    assign rd     = instr[11:7];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // Opcode and function fields to operation
    // Unknown encodings fall to NOP
    always_comb begin
        op = rv_core_pkg::NOP;
        case (opcode)
            rv_isa_pkg::OP_LUI: op = rv_core_pkg::LUI;
            rv_isa_pkg::OP_JAL: op = rv_core_pkg::JAL;
            rv_isa_pkg::OP_IMM: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD: op = rv_core_pkg::ADD;
                    rv_isa_pkg::F3_SLT: op = rv_core_pkg::SLT;
                    rv_isa_pkg::F3_XOR: op = rv_core_pkg::XOR;
                    rv_isa_pkg::F3_OR:  op = rv_core_pkg::OR;
                    rv_isa_pkg::F3_AND: op = rv_core_pkg::AND;
                    default:            op = rv_core_pkg::NOP;
                endcase
            end
            rv_isa_pkg::OP_REG: begin
                if (funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_ADD) begin
                    op = rv_core_pkg::SUB;
                end else if (funct7 == rv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD: op = rv_core_pkg::ADD;
                        rv_isa_pkg::F3_SLL: op = rv_core_pkg::SLL;
                        rv_isa_pkg::F3_SLT: op = rv_core_pkg::SLT;
                        rv_isa_pkg::F3_XOR: op = rv_core_pkg::XOR;
                        rv_isa_pkg::F3_SRL: op = rv_core_pkg::SRL;
                        rv_isa_pkg::F3_OR:  op = rv_core_pkg::OR;
                        rv_isa_pkg::F3_AND: op = rv_core_pkg::AND;
                        default:            op = rv_core_pkg::NOP;
                    endcase
                end
            end
            rv_isa_pkg::OP_LOAD: begin
                if (funct3 == rv_isa_pkg::F3_WORD) op = rv_core_pkg::LW;
            end
            rv_isa_pkg::OP_STORE: begin
                if (funct3 == rv_isa_pkg::F3_WORD) op = rv_core_pkg::SW;
            end
            rv_isa_pkg::OP_BRANCH: begin
                if (funct3 == rv_isa_pkg::F3_BEQ) op = rv_core_pkg::BEQ;
                else if (funct3 == rv_isa_pkg::F3_BNE) op = rv_core_pkg::BNE;
            end
            default: op = rv_core_pkg::NOP;
        endcase
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_LUI:    imm = {instr[31:12], 12'b0};
            rv_isa_pkg::OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_isa_pkg::OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7],
                                          instr[30:25], instr[11:8], 1'b0};
            rv_isa_pkg::OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                          instr[20], instr[30:21], 1'b0};
            default:               imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    // ALU immediates take the immediate in place of rs2
    assign imm_operand = (opcode == rv_isa_pkg::OP_IMM);
    assign use_rs1     = !(op inside {rv_core_pkg::NOP, rv_core_pkg::LUI, rv_core_pkg::JAL});
    assign use_rs2     = use_rs1 && !imm_operand && op != rv_core_pkg::LW;

    // Execute-stage rd comes back from our own register
    assign ex_writes = exec_bus.valid && rv_core_pkg::op_writes_rd(exec_bus.op)
                       && exec_bus.rd != '0;

    // Retire is covered by the write-through read
    assign hazard_o = valid_i && ex_writes
                      && ((use_rs1 && rs1_o == exec_bus.rd)
                          || (use_rs2 && rs2_o == exec_bus.rd));

    ////////////////////////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exec_bus.valid <= 1'b0;
            exec_bus.op    <= rv_core_pkg::NOP;
        end else begin
            // Bubble on hazard, squash on redirect
            exec_bus.valid <= valid_i && !hazard_o && !jump_i;
            exec_bus.op    <= op;
        end
    end

    always_ff @(posedge clk) begin
        exec_bus.pc       <= pc_i;
        exec_bus.rs1_data <= rs1_data_i;
        exec_bus.rs2_data <= imm_operand ? imm : rs2_data_i;
        exec_bus.imm      <= imm;
        exec_bus.rd       <= rd;
    end

    // Fetch presents a stalled instruction again on the next cycle
    assert property (@(posedge clk) disable iff (!reset_n)
        hazard_o && !jump_i |=> valid_i && $stable(pc_i))
        else $error("decode: stalled instruction not held by fetch");

endmodule

/* decode/reg_bank.sv */
// Integer register bank
`timescale 1ns/1ps
`include "rv_core_params.svh"

module reg_bank (
    input  logic                  clk,
    input  logic                  reset_n,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    input  logic                  we_i,
    input  rv_core_pkg::word_t    data_i,
    output rv_core_pkg::word_t    data1_o,
    output rv_core_pkg::word_t    data2_o
);

    // x0 has no storage
    rv_core_pkg::word_t regs [1:`NUM_REGS-1];

    // x0 reads zero, a same-cycle write passes straight through
    function automatic rv_core_pkg::word_t read_port(rv_core_pkg::reg_idx_t idx);
        if (idx == '0) return '0;
        if (we_i && idx == rd_i) return data_i;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    always_comb begin
        data1_o = read_port(rs1_i);
        data2_o = read_port(rs2_i);
    end

endmodule

/* rv_core.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
common/exec_bus_if.sv
src/fetch_unit.sv
decode/reg_bank.sv
decode/decode_unit.sv
src/execute_unit.sv
src/retire_unit.sv
src/rv_core.sv
testbench/tb_rv_core.sv

/* src/execute_unit.sv */
// Execute stage
`timescale 1ns/1ps

module execute_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    exec_bus_if.execute_mp        exec_bus,
    output logic                  jump_o,
    output rv_core_pkg::word_t    jump_target_o,
    output logic                  dmem_en_o,
    output logic                  dmem_we_o,
    output rv_core_pkg::word_t    dmem_addr_o,
    output rv_core_pkg::word_t    dmem_wdata_o,
    output rv_core_pkg::reg_idx_t rd_retire_o,
    output rv_core_pkg::word_t    result_retire_o,
    output logic                  we_retire_o,
    output logic                  load_retire_o
);

    rv_core_pkg::word_t    a;
    rv_core_pkg::word_t    b;
    rv_core_pkg::word_t    mem_addr;
    rv_core_pkg::word_t    result;
    logic                  taken;
    rv_core_pkg::exec_op_e op_retire;

    assign a = exec_bus.rs1_data;
    assign b = exec_bus.rs2_data;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (exec_bus.op)
            rv_core_pkg::ADD: result = a + b;
            rv_core_pkg::SUB: result = a - b;
            rv_core_pkg::SLL: result = a << b[4:0];
            rv_core_pkg::SLT: result = rv_core_pkg::word_t'($signed(a) < $signed(b));
            rv_core_pkg::XOR: result = a ^ b;
            rv_core_pkg::SRL: result = a >> b[4:0];
            rv_core_pkg::OR:  result = a | b;
            rv_core_pkg::AND: result = a & b;
            rv_core_pkg::LUI: result = exec_bus.imm;
            // Link address
            rv_core_pkg::JAL: result = exec_bus.pc + rv_core_pkg::word_t'(4);
            default:          result = mem_addr;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch resolution and data request
    ////////////////////////////////////////////////////////////

    assign taken = (exec_bus.op == rv_core_pkg::BEQ && a == b)
                   || (exec_bus.op == rv_core_pkg::BNE && a != b);

    assign jump_o        = exec_bus.valid && (taken || exec_bus.op == rv_core_pkg::JAL);
    assign jump_target_o = exec_bus.pc + exec_bus.imm;

    // Word port only, low bits dropped
    assign mem_addr = (a + exec_bus.imm) & ~rv_core_pkg::word_t'(3);

    assign dmem_en_o    = exec_bus.valid
                          && exec_bus.op inside {rv_core_pkg::LW, rv_core_pkg::SW};
    assign dmem_we_o    = exec_bus.valid && exec_bus.op == rv_core_pkg::SW;
    assign dmem_addr_o  = mem_addr;
    assign dmem_wdata_o = b;

    ////////////////////////////////////////////////////////////
    // Execute/retire register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            we_retire_o <= 1'b0;
            op_retire   <= rv_core_pkg::NOP;
        end else begin
            we_retire_o <= exec_bus.valid && rv_core_pkg::op_writes_rd(exec_bus.op);
            op_retire   <= exec_bus.valid ? exec_bus.op : rv_core_pkg::NOP;
        end
    end

    always_ff @(posedge clk) begin
        rd_retire_o     <= exec_bus.rd;
        result_retire_o <= result;
    end

    // Load data arrives during retire
    assign load_retire_o = (op_retire == rv_core_pkg::LW);

endmodule

/* src/fetch_unit.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`include "rv_core_params.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               hazard_i,
    input  logic               jump_i,
    input  rv_core_pkg::word_t jump_target_i,
    output logic               imem_en_o,
    output rv_core_pkg::word_t imem_addr_o,
    output logic               valid_o,
    output rv_core_pkg::word_t pc_o
);

    // Next address to request
    rv_core_pkg::word_t pc;

    // Memory is always ready, so request every cycle
    assign imem_en_o = 1'b1;

    // On a hazard re-request the word held in decode
    assign imem_addr_o = hazard_i ? pc_o : pc;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc      <= `RESET_PC;
            valid_o <= 1'b0;
        end else begin
            // Word in flight is dropped on a redirect
            valid_o <= !jump_i;
            if (jump_i) begin
                pc <= jump_target_i;
            end else if (!hazard_i) begin
                pc <= pc + rv_core_pkg::word_t'(4);
            end
        end
    end

    // Address of the word returning next cycle
    always_ff @(posedge clk) begin
        pc_o <= imem_addr_o;
    end

    // Fetch never leaves word alignment
    assert property (@(posedge clk) disable iff (!reset_n)
        imem_en_o |-> imem_addr_o[1:0] == 2'b00)
        else $error("fetch: misaligned address %h", imem_addr_o);

endmodule

/* src/retire_unit.sv */
// Retire stage
`timescale 1ns/1ps

module retire_unit (
    input  logic                  load_i,
    input  rv_core_pkg::word_t    result_i,
    input  rv_core_pkg::word_t    dmem_rdata_i,
    input  logic                  we_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    output logic                  rf_we_o,
    output rv_core_pkg::reg_idx_t rf_rd_o,
    output rv_core_pkg::word_t    rf_data_o
);

    // Memory word for LW, ALU result for the rest
    assign rf_data_o = load_i ? dmem_rdata_i : result_i;

    // x0 stays zero
    assign rf_we_o = we_i && rd_i != '0;
    assign rf_rd_o = rd_i;

endmodule

/* src/rv_core.sv */
// RV32I four-stage core
`timescale 1ns/1ps

module rv_core (
    input  logic               clk,
    input  logic               reset_n,
    output logic               imem_en_o,
    output rv_core_pkg::word_t imem_addr_o,
    input  rv_core_pkg::word_t imem_data_i,
    output logic               dmem_en_o,
    output logic               dmem_we_o,
    output rv_core_pkg::word_t dmem_addr_o,
    output rv_core_pkg::word_t dmem_wdata_o,
    input  rv_core_pkg::word_t dmem_rdata_i
);

    ////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////

    // Redirect and interlock
    logic                  jump;
    rv_core_pkg::word_t    jump_target;
    logic                  hazard;

    // Fetch to decode
    logic                  fetch_valid;
    rv_core_pkg::word_t    fetch_pc;

    // Register bank reads
    rv_core_pkg::reg_idx_t rs1;
    rv_core_pkg::reg_idx_t rs2;
    rv_core_pkg::word_t    rs1_data;
    rv_core_pkg::word_t    rs2_data;

    // Execute to retire
    rv_core_pkg::reg_idx_t rd_retire;
    rv_core_pkg::word_t    result_retire;
    logic                  we_retire;
    logic                  load_retire;

    // Register bank write port
    logic                  rf_we;
    rv_core_pkg::reg_idx_t rf_rd;
    rv_core_pkg::word_t    rf_data;

    exec_bus_if exec_bus_i ();

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .hazard_i     (hazard),
        .jump_i       (jump),
        .jump_target_i(jump_target),
        .imem_en_o    (imem_en_o),
        .imem_addr_o  (imem_addr_o),
        .valid_o      (fetch_valid),
        .pc_o         (fetch_pc)
    );

    decode_unit decode_unit_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .valid_i      (fetch_valid),
        .pc_i         (fetch_pc),
        .instruction_i(imem_data_i),
        .jump_i       (jump),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .hazard_o     (hazard),
        .exec_bus     (exec_bus_i.decode_mp)
    );

    reg_bank reg_bank_i (
        .clk    (clk),
        .reset_n(reset_n),
        .rs1_i  (rs1),
        .rs2_i  (rs2),
        .rd_i   (rf_rd),
        .we_i   (rf_we),
        .data_i (rf_data),
        .data1_o(rs1_data),
        .data2_o(rs2_data)
    );

    execute_unit execute_unit_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .exec_bus       (exec_bus_i.execute_mp),
        .jump_o         (jump),
        .jump_target_o  (jump_target),
        .dmem_en_o      (dmem_en_o),
        .dmem_we_o      (dmem_we_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .rd_retire_o    (rd_retire),
        .result_retire_o(result_retire),
        .we_retire_o    (we_retire),
        .load_retire_o  (load_retire)
    );

    retire_unit retire_unit_i (
        .load_i      (load_retire),
        .result_i    (result_retire),
        .dmem_rdata_i(dmem_rdata_i),
        .we_i        (we_retire),
        .rd_i        (rd_retire),
        .rf_we_o     (rf_we),
        .rf_rd_o     (rf_rd),
        .rf_data_o   (rf_data)
    );

endmodule

/* testbench/rv_core_stim.txt */
# I <address> <instruction word> : program image, hex
# S <address> <data> : expected stores in order, hex; E ends the file
# ALU immediates and registers, dependents right after producers
I 00000000 00500093
I 00000004 FFD00113
I 00000008 002081B3
I 0000000C 10302023
I 00000010 40208233
I 00000014 001122B3
I 00000018 00521333
I 0000001C 005153B3
I 00000020 10602223
I 00000024 10702423
I 00000028 12345437
I 0000002C 67846413
I 00000030 FFF44493
I 00000034 0F04F513
I 00000038 FFE12593
I 0000003C 00B54633
I 00000040 00866633
I 00000044 10C02623
I 00000048 10902823
# Write to x0, then store x0
I 0000004C 00700013
I 00000050 10002A23
# BEQ taken, BNE not taken, JAL with link; stores to 1Fx are skipped
I 00000054 00108663
I 00000058 1E102823
I 0000005C 1E102A23
I 00000060 00109463
I 00000064 10402C23
I 00000068 00C006EF
I 0000006C 1E102C23
I 00000070 1E102E23
I 00000074 10D02E23
# Load feeding a store, then spin
I 00000078 10402703
I 0000007C 12E02023
I 00000080 0000006F
S 00000100 00000002
S 00000104 00000010
S 00000108 7FFFFFFE
S 0000010C 123456F9
S 00000110 EDCBA987
S 00000114 00000000
S 00000118 00000008
S 0000011C 0000006C
S 00000120 00000010
E

/* testbench/tb_rv_core.sv */
// Core testbench
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 10;
    localparam int    MEM_WORDS    = 256;
    localparam int    DRAIN_CYCLES = 20;
    localparam string STIM_FILE    = "testbench/rv_core_stim.txt";

    logic               clk;
    logic               reset_n;
    logic               imem_en;
    rv_core_pkg::word_t imem_addr;
    rv_core_pkg::word_t imem_data;
    logic               dmem_en;
    logic               dmem_we;
    rv_core_pkg::word_t dmem_addr;
    rv_core_pkg::word_t dmem_wdata;
    rv_core_pkg::word_t dmem_rdata;

    // Memory models and expected store sequence
    rv_core_pkg::word_t imem [0:MEM_WORDS-1];
    rv_core_pkg::word_t dmem [0:MEM_WORDS-1];
    rv_core_pkg::word_t exp_addr [$];
    rv_core_pkg::word_t exp_data [$];
    rv_core_pkg::word_t imem_req_addr;
    rv_core_pkg::word_t dmem_req_addr;

    int   error_count;
    int   store_count;
    int   num_stores;
    int   prog_words;
    logic stim_loaded;

    rv_core rv_core_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .imem_en_o   (imem_en),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dmem_en_o   (dmem_en),
        .dmem_we_o   (dmem_we),
        .dmem_addr_o (dmem_addr),
        .dmem_wdata_o(dmem_wdata),
        .dmem_rdata_i(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Memory models with a one-cycle read
    ////////////////////////////////////////////////////////////

    function automatic int word_index(input rv_core_pkg::word_t addr,
                                      input rv_core_pkg::word_t base);
        return int'(((addr - base) >> 2) % MEM_WORDS);
    endfunction

    // Requests latched at the clock edge only while enabled
    always @(posedge clk) begin
        if (imem_en) begin
            imem_req_addr <= imem_addr;
        end
        if (dmem_en) begin
            dmem_req_addr <= dmem_addr;
        end
        if (dmem_en && dmem_we) begin
            dmem[word_index(dmem_addr, '0)] <= dmem_wdata;
        end
    end

    // Read data presented on the falling edge of the next cycle
    always @(negedge clk) begin
        imem_data  <= imem[word_index(imem_req_addr, `RESET_PC)];
        dmem_rdata <= dmem[word_index(dmem_req_addr, '0)];
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic compare_values(input rv_core_pkg::word_t got,
                                  input rv_core_pkg::word_t expected,
                                  input string what);
        if (got !== expected) begin
            $display("** Error @ %0t: %s mismatch, got %h expected %h",
                     $time, what, got, expected);
            error_count++;
        end
    endtask

    // Store port comes from the execute register and is stable at the falling edge
    task automatic sample_store_port();
        @(negedge clk);
        if (dmem_en && dmem_we) begin
            if (store_count >= num_stores) begin
                $display("Unexpected store of %h to address %h at %0t",
                         dmem_wdata, dmem_addr, $time);
                error_count++;
            end else begin
                compare_values(dmem_addr, exp_addr[store_count], "store address");
                compare_values(dmem_wdata, exp_data[store_count], "store data");
            end
            store_count++;
        end
    endtask

    // Records are I, S or E and lines starting with # are skipped
    task automatic load_stimulus();
        int                 fd;
        int                 code;
        logic [7:0]         kind;
        logic [8*128-1:0]   comment_text;
        rv_core_pkg::word_t addr;
        rv_core_pkg::word_t value;
        logic               done;
        fd   = $fopen(STIM_FILE, "r");
        done = 1'b0;
        if (fd == 0) begin
            $display("Could not open stimulus file %s", STIM_FILE);
            error_count++;
            done = 1'b1;
        end
        while (!done && !$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1 || kind == "E") begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(comment_text, fd);
            end else if (kind == "I") begin
                code = $fscanf(fd, " %h %h", addr, value);
                imem[word_index(addr, `RESET_PC)] = value;
                prog_words++;
            end else if (kind == "S") begin
                code = $fscanf(fd, " %h %h", addr, value);
                exp_addr.push_back(addr);
                exp_data.push_back(value);
            end else begin
                $display("Unknown record type %c in %s", kind, STIM_FILE);
                error_count++;
                done = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        num_stores = exp_addr.size();
        if (num_stores == 0) begin
            $display("Stimulus file holds no expected stores");
            error_count++;
        end
    endtask

    task automatic finish_run(input logic timed_out);
        int missing;
        missing = (store_count >= num_stores) ? 0 : num_stores - store_count;
        $display("Run ended: %0d errors, %0d missing stores", error_count, missing);
        if (!timed_out && error_count == 0 && missing == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset_n       = 1'b0;
        imem_data     = '0;
        dmem_rdata    = '0;
        imem_req_addr = `RESET_PC;
        dmem_req_addr = '0;
        error_count   = 0;
        store_count   = 0;
        num_stores    = 0;
        prog_words    = 0;
        stim_loaded   = 1'b0;
        // Zero words decode as NOP
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_stimulus();
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        compare_values(rv_core_pkg::word_t'(dmem_en), 32'd0, "dmem_en_o in reset");
        compare_values(rv_core_pkg::word_t'(dmem_we), 32'd0, "dmem_we_o in reset");
        reset_n = 1'b1;

        // First cycle after reset
        #2;
        compare_values(rv_core_pkg::word_t'(imem_en), 32'd1, "imem_en_o after reset");
        compare_values(imem_addr, `RESET_PC, "first fetch address");
        compare_values(rv_core_pkg::word_t'(dmem_en), 32'd0, "dmem_en_o after reset");
        compare_values(rv_core_pkg::word_t'(dmem_we), 32'd0, "dmem_we_o after reset");

        while (store_count < num_stores) begin
            sample_store_port();
        end
        // Catch stray stores from a missed squash
        repeat (DRAIN_CYCLES) begin
            sample_store_port();
        end
        finish_run(1'b0);
    end

    // Budget scales with the program length
    initial begin
        wait (stim_loaded);
        repeat (RESET_CYCLES + 40 * prog_words + 200) @(posedge clk);
        $display("Timeout: only %0d of %0d expected stores were seen",
                 store_count, num_stores);
        finish_run(1'b1);
    end

endmodule
